// File: cpu8_pkg.sv
`default_nettype none

package cpu8_pkg;

    localparam int WORD_W    = 8;  // data and address width
    localparam int REG_IDX_W = 2;  // register index
    localparam int OPC_W     = 4;
    localparam int NUM_REGS  = 4;

    // opcodes, 14 and 15 decode as nop
    localparam logic [OPC_W-1:0] OP_NOP = 4'd0;
    localparam logic [OPC_W-1:0] OP_MOV = 4'd1;   // ra = rb
    localparam logic [OPC_W-1:0] OP_ADD = 4'd2;
    localparam logic [OPC_W-1:0] OP_SUB = 4'd3;
    localparam logic [OPC_W-1:0] OP_AND = 4'd4;
    localparam logic [OPC_W-1:0] OP_OR  = 4'd5;
    localparam logic [OPC_W-1:0] OP_OUT = 4'd6;   // out_port = ra
    localparam logic [OPC_W-1:0] OP_IN  = 4'd7;   // ra = in_port
    localparam logic [OPC_W-1:0] OP_LDM = 4'd8;   // two words, immediate follows
    localparam logic [OPC_W-1:0] OP_LDD = 4'd9;   // ra = mem[rb]
    localparam logic [OPC_W-1:0] OP_STD = 4'd10;  // mem[rb] = ra
    localparam logic [OPC_W-1:0] OP_JZ  = 4'd11;
    localparam logic [OPC_W-1:0] OP_JC  = 4'd12;
    localparam logic [OPC_W-1:0] OP_JMP = 4'd13;

    // bit positions in the flag register
    localparam int FLAG_Z = 0;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 2;
    localparam int FLAG_V = 3;

    localparam logic [1:0] FWD_NONE = 2'd0;  // operand from id/ex
    localparam logic [1:0] FWD_MEM  = 2'd1;  // from ex/mem result
    localparam logic [1:0] FWD_WB   = 2'd2;  // from writeback data

    localparam logic [1:0] RES_ALU = 2'd0;
    localparam logic [1:0] RES_IN  = 2'd1;   // sampled in_port
    localparam logic [1:0] RES_IMM = 2'd2;   // ldm immediate

    localparam logic WB_ALU = 1'b0;
    localparam logic WB_MEM = 1'b1;

    // one instruction word, either fields or the raw ldm immediate
    typedef union packed {
        struct packed {
            logic [OPC_W-1:0]     opcode;
            logic [REG_IDX_W-1:0] ra;
            logic [REG_IDX_W-1:0] rb;
        } f;
        logic [WORD_W-1:0] raw;
    } instr_u;

endpackage

`default_nettype wire

// File: cpu8_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module cpu8_fetch (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire [cpu8_pkg::WORD_W-1:0]  instr_word,
    input  wire                         stall,
    input  wire                         flush_ifid,
    input  wire                         branch_taken,
    input  wire [cpu8_pkg::WORD_W-1:0]  branch_target,
    output logic [cpu8_pkg::WORD_W-1:0] pc,
    output cpu8_pkg::instr_u            ifid_word
);
    import cpu8_pkg::*;

    logic [WORD_W-1:0] pc_nxt;

    always_comb begin
        if (branch_taken) begin
            pc_nxt = branch_target;  // redirect wins over stall
        end else if (stall) begin
            pc_nxt = pc;
        end else begin
            pc_nxt = pc + 1'b1;  // wraps at 255
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc            <= '0;
            ifid_word.raw <= {OP_NOP, 4'h0};
        end else begin
            pc <= pc_nxt;
            if (flush_ifid) begin
                ifid_word.raw <= {OP_NOP, 4'h0};  // drop wrong-path word
            end else if (!stall) begin
                ifid_word.raw <= instr_word;
            end
        end
    end

endmodule

`default_nettype wire

// File: cpu8_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module cpu8_regfile (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire [cpu8_pkg::REG_IDX_W-1:0]  rd_a_idx,
    input  wire [cpu8_pkg::REG_IDX_W-1:0]  rd_b_idx,
    input  wire                            wb_en,
    input  wire [cpu8_pkg::REG_IDX_W-1:0]  wb_idx,
    input  wire [cpu8_pkg::WORD_W-1:0]     wb_data,
    output logic [cpu8_pkg::WORD_W-1:0]    rd_a_data,
    output logic [cpu8_pkg::WORD_W-1:0]    rd_b_data
);
    import cpu8_pkg::*;

    logic [WORD_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_idx] <= wb_data;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign rd_a_data = (wb_en && wb_idx == rd_a_idx) ? wb_data : regs[rd_a_idx];
    assign rd_b_data = (wb_en && wb_idx == rd_b_idx) ? wb_data : regs[rd_b_idx];

endmodule

`default_nettype wire

// File: cpu8_decode.sv
`timescale 1ns/1ns
`default_nettype none

module cpu8_decode (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire cpu8_pkg::instr_u           ifid_word,
    input  wire [cpu8_pkg::WORD_W-1:0]      in_port,
    input  wire [cpu8_pkg::WORD_W-1:0]      rd_a_data,
    input  wire [cpu8_pkg::WORD_W-1:0]      rd_b_data,
    input  wire                             bubble_idex,
    input  wire                             branch_taken,
    output logic [cpu8_pkg::REG_IDX_W-1:0]  rd_a_idx,
    output logic [cpu8_pkg::REG_IDX_W-1:0]  rd_b_idx,
    output logic [cpu8_pkg::OPC_W-1:0]      idex_op,
    output logic [cpu8_pkg::REG_IDX_W-1:0]  idex_ra_idx,
    output logic [cpu8_pkg::REG_IDX_W-1:0]  idex_rb_idx,
    output logic [cpu8_pkg::WORD_W-1:0]     idex_a,
    output logic [cpu8_pkg::WORD_W-1:0]     idex_b,
    output logic [cpu8_pkg::WORD_W-1:0]     idex_aux,
    output logic [1:0]                      idex_res_sel,
    output logic [cpu8_pkg::REG_IDX_W-1:0]  idex_dest,
    output logic                            idex_reg_we,
    output logic                            idex_mem_rd,
    output logic                            idex_mem_we,
    output logic                            idex_out_we
);
    import cpu8_pkg::*;

    logic                 imm_pend;   // if/id holds an ldm immediate
    logic [REG_IDX_W-1:0] imm_dest;   // ldm target across the two slots
    logic                 ldm_start;
    logic [OPC_W-1:0]     dec_op;
    logic [1:0]           dec_res_sel;
    logic [REG_IDX_W-1:0] dec_dest;
    logic                 dec_reg_we;
    logic                 dec_mem_rd;
    logic                 dec_mem_we;
    logic                 dec_out_we;

    assign rd_a_idx  = ifid_word.f.ra;
    assign rd_b_idx  = ifid_word.f.rb;
    assign ldm_start = !imm_pend && (ifid_word.f.opcode == OP_LDM);

    always_comb begin
        dec_op      = ifid_word.f.opcode;
        dec_res_sel = RES_ALU;
        dec_dest    = ifid_word.f.ra;  // every writer targets ra
        dec_reg_we  = 1'b0;
        dec_mem_rd  = 1'b0;
        dec_mem_we  = 1'b0;
        dec_out_we  = 1'b0;
        if (imm_pend) begin
            dec_op      = OP_LDM;  // second slot, the actual write
            dec_res_sel = RES_IMM;
            dec_dest    = imm_dest;
            dec_reg_we  = 1'b1;
        end else begin
            case (ifid_word.f.opcode)
                OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_OR: dec_reg_we = 1'b1;
                OP_OUT: dec_out_we = 1'b1;
                OP_IN: begin
                    dec_reg_we  = 1'b1;
                    dec_res_sel = RES_IN;
                end
                OP_LDM: dec_op = OP_NOP;  // first slot goes out as a bubble
                OP_LDD: begin
                    dec_reg_we = 1'b1;
                    dec_mem_rd = 1'b1;
                end
                OP_STD: dec_mem_we = 1'b1;
                OP_JZ, OP_JC, OP_JMP: dec_op = ifid_word.f.opcode;  // taken in execute
                default: dec_op = OP_NOP;  // nop, 14, 15
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || branch_taken) begin
            imm_pend <= 1'b0;
        end else if (!bubble_idex) begin
            imm_pend <= ldm_start;  // held through a stall
        end
    end

    // id/ex control, bubble on stall or kill
    always_ff @(posedge clk) begin
        if (!rst_n || bubble_idex) begin
            idex_op      <= OP_NOP;
            idex_res_sel <= RES_ALU;
            idex_reg_we  <= 1'b0;
            idex_mem_rd  <= 1'b0;
            idex_mem_we  <= 1'b0;
            idex_out_we  <= 1'b0;
        end else begin
            idex_op      <= dec_op;
            idex_res_sel <= dec_res_sel;
            idex_reg_we  <= dec_reg_we;
            idex_mem_rd  <= dec_mem_rd;
            idex_mem_we  <= dec_mem_we;
            idex_out_we  <= dec_out_we;
        end
    end

    always_ff @(posedge clk) begin
        idex_ra_idx <= ifid_word.f.ra;
        idex_rb_idx <= ifid_word.f.rb;
        idex_a      <= rd_a_data;
        idex_b      <= rd_b_data;
        idex_aux    <= imm_pend ? ifid_word.raw : in_port;  // raw view, or in_port sample
        idex_dest   <= dec_dest;
        if (ldm_start) begin
            imm_dest <= ifid_word.f.ra;
        end
    end

endmodule

`default_nettype wire

// File: cpu8_hazard.sv
`timescale 1ns/1ns
`default_nettype none

module cpu8_hazard (
    input  wire cpu8_pkg::instr_u           ifid_word,
    input  wire [cpu8_pkg::REG_IDX_W-1:0]   idex_dest,
    input  wire                             idex_mem_rd,
    input  wire [cpu8_pkg::REG_IDX_W-1:0]   idex_ra_idx,
    input  wire [cpu8_pkg::REG_IDX_W-1:0]   idex_rb_idx,
    input  wire [cpu8_pkg::REG_IDX_W-1:0]   exmem_dest,
    input  wire                             exmem_reg_we,
    input  wire [cpu8_pkg::REG_IDX_W-1:0]   memwb_dest,
    input  wire                             memwb_reg_we,
    input  wire                             branch_taken,
    output logic                            stall,
    output logic                            flush_ifid,
    output logic                            bubble_idex,
    output logic [1:0]                      fwd_a,
    output logic [1:0]                      fwd_b
);
    import cpu8_pkg::*;

    logic [OPC_W-1:0] op;
    logic             uses_ra;
    logic             uses_rb;

    // during an ldm immediate ex holds the ldm bubble, so no false stall
    assign op      = ifid_word.f.opcode;
    assign uses_ra = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_OUT, OP_STD};
    assign uses_rb = op inside {OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_OR,
                                OP_LDD, OP_STD, OP_JZ, OP_JC, OP_JMP};

    // load data only exists after mem, wait one cycle then take it from wb
    assign stall = idex_mem_rd && ((uses_ra && idex_dest == ifid_word.f.ra) ||
                                   (uses_rb && idex_dest == ifid_word.f.rb));

    assign flush_ifid  = branch_taken;          // word being fetched
    assign bubble_idex = stall || branch_taken;  // word in decode

    // youngest producer first
    assign fwd_a = (exmem_reg_we && exmem_dest == idex_ra_idx) ? FWD_MEM :
                   (memwb_reg_we && memwb_dest == idex_ra_idx) ? FWD_WB : FWD_NONE;
    assign fwd_b = (exmem_reg_we && exmem_dest == idex_rb_idx) ? FWD_MEM :
                   (memwb_reg_we && memwb_dest == idex_rb_idx) ? FWD_WB : FWD_NONE;

endmodule

`default_nettype wire

// File: cpu8_execute.sv
`timescale 1ns/1ns
`default_nettype none

module cpu8_execute (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire [cpu8_pkg::OPC_W-1:0]       idex_op,
    input  wire [cpu8_pkg::WORD_W-1:0]      idex_a,
    input  wire [cpu8_pkg::WORD_W-1:0]      idex_b,
    input  wire [cpu8_pkg::WORD_W-1:0]      idex_aux,
    input  wire [1:0]                       idex_res_sel,
    input  wire [cpu8_pkg::REG_IDX_W-1:0]   idex_dest,
    input  wire                             idex_reg_we,
    input  wire                             idex_mem_rd,
    input  wire                             idex_mem_we,
    input  wire                             idex_out_we,
    input  wire [1:0]                       fwd_a,
    input  wire [1:0]                       fwd_b,
    input  wire [cpu8_pkg::WORD_W-1:0]      wb_data,
    output logic                            branch_taken,
    output logic [cpu8_pkg::WORD_W-1:0]     branch_target,
    output logic [cpu8_pkg::WORD_W-1:0]     exmem_result,
    output logic [cpu8_pkg::WORD_W-1:0]     exmem_store,
    output logic [cpu8_pkg::REG_IDX_W-1:0]  exmem_dest,
    output logic                            exmem_reg_we,
    output logic                            exmem_mem_rd,
    output logic                            exmem_mem_we,
    output logic                            exmem_out_we
);
    import cpu8_pkg::*;

    logic [WORD_W-1:0] op_a;
    logic [WORD_W-1:0] op_b;
    logic              is_sub;
    logic [WORD_W-1:0] b_eff;     // rb, inverted for sub
    logic [WORD_W:0]   sum;       // msb is carry out
    logic [WORD_W-1:0] alu_res;
    logic [3:0]        flags;
    logic [3:0]        flags_nxt;

    assign op_a = (fwd_a == FWD_MEM) ? exmem_result : (fwd_a == FWD_WB) ? wb_data : idex_a;
    assign op_b = (fwd_b == FWD_MEM) ? exmem_result : (fwd_b == FWD_WB) ? wb_data : idex_b;

    // sub as a + ~b + 1, carry out high means no borrow
    assign is_sub = (idex_op == OP_SUB);
    assign b_eff  = is_sub ? ~op_b : op_b;
    assign sum    = {1'b0, op_a} + {1'b0, b_eff} + {{WORD_W{1'b0}}, is_sub};

    always_comb begin
        flags_nxt = flags;
        case (idex_op)
            OP_ADD, OP_SUB: begin
                alu_res           = sum[WORD_W-1:0];
                flags_nxt[FLAG_C] = sum[WORD_W];
                flags_nxt[FLAG_V] = (op_a[WORD_W-1] == b_eff[WORD_W-1]) &&
                                    (alu_res[WORD_W-1] != op_a[WORD_W-1]);
            end
            OP_AND: alu_res = op_a & op_b;
            OP_OR: alu_res = op_a | op_b;
            default: alu_res = op_b;  // mov, and the ldd/std address
        endcase
        if (idex_op inside {OP_ADD, OP_SUB, OP_AND, OP_OR}) begin
            flags_nxt[FLAG_Z] = (alu_res == '0);
            flags_nxt[FLAG_N] = alu_res[WORD_W-1];
        end
    end

    // flags already hold the result of the instruction just ahead
    always_comb begin
        case (idex_op)
            OP_JZ: branch_taken = flags[FLAG_Z];
            OP_JC: branch_taken = flags[FLAG_C];
            OP_JMP: branch_taken = 1'b1;
            default: branch_taken = 1'b0;
        endcase
    end

    assign branch_target = op_b;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flags        <= '0;
            exmem_reg_we <= 1'b0;
            exmem_mem_rd <= 1'b0;
            exmem_mem_we <= 1'b0;
            exmem_out_we <= 1'b0;
        end else begin
            flags        <= flags_nxt;
            exmem_reg_we <= idex_reg_we;
            exmem_mem_rd <= idex_mem_rd;
            exmem_mem_we <= idex_mem_we;
            exmem_out_we <= idex_out_we;
        end
    end

    always_ff @(posedge clk) begin
        exmem_result <= (idex_res_sel == RES_ALU) ? alu_res : idex_aux;
        exmem_store  <= op_a;  // std data and out value
        exmem_dest   <= idex_dest;
    end

endmodule

`default_nettype wire

// File: cpu8_memory.sv
`timescale 1ns/1ns
`default_nettype none

module cpu8_memory #(
    parameter int MEM_DEPTH = 256  // power of two, at most 256
) (
    input  wire                         clk,
    input  wire [cpu8_pkg::WORD_W-1:0]  addr_a,
    input  wire [cpu8_pkg::WORD_W-1:0]  addr_b,
    input  wire                         we_b,
    input  wire [cpu8_pkg::WORD_W-1:0]  wdata_b,
    output logic [cpu8_pkg::WORD_W-1:0] rdata_a,
    output logic [cpu8_pkg::WORD_W-1:0] rdata_b
);
    import cpu8_pkg::*;

    localparam int AW = $clog2(MEM_DEPTH);

    logic [WORD_W-1:0] mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (we_b) begin
            mem[addr_b[AW-1:0]] <= wdata_b;  // upper address bits wrap
        end
    end

    assign rdata_a = mem[addr_a[AW-1:0]];  // instruction port
    assign rdata_b = mem[addr_b[AW-1:0]];  // data port

endmodule

`default_nettype wire

// File: cpu8_writeback.sv
`timescale 1ns/1ns
`default_nettype none

module cpu8_writeback (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire [cpu8_pkg::WORD_W-1:0]      exmem_result,
    input  wire [cpu8_pkg::REG_IDX_W-1:0]   exmem_dest,
    input  wire                             exmem_reg_we,
    input  wire                             exmem_mem_rd,
    input  wire                             exmem_out_we,
    input  wire [cpu8_pkg::WORD_W-1:0]      exmem_store,
    input  wire [cpu8_pkg::WORD_W-1:0]      mem_rdata,
    output logic                            wb_en,
    output logic [cpu8_pkg::REG_IDX_W-1:0]  wb_idx,
    output logic [cpu8_pkg::WORD_W-1:0]     wb_data,
    output logic [cpu8_pkg::WORD_W-1:0]     out_port
);
    import cpu8_pkg::*;

    logic              memwb_sel;
    logic              memwb_out_we;
    logic [WORD_W-1:0] memwb_alu;
    logic [WORD_W-1:0] memwb_mem;
    logic [WORD_W-1:0] memwb_out;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_en        <= 1'b0;
            memwb_sel    <= WB_ALU;
            memwb_out_we <= 1'b0;
            out_port     <= '0;
        end else begin
            wb_en        <= exmem_reg_we;
            memwb_sel    <= exmem_mem_rd ? WB_MEM : WB_ALU;
            memwb_out_we <= exmem_out_we;
            if (memwb_out_we) begin
                out_port <= memwb_out;  // holds until the next out
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_idx    <= exmem_dest;
        memwb_alu <= exmem_result;
        memwb_mem <= mem_rdata;   // async port b read in mem stage
        memwb_out <= exmem_store;
    end

    assign wb_data = (memwb_sel == WB_MEM) ? memwb_mem : memwb_alu;

endmodule

`default_nettype wire

// File: cpu8_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu8_top #(
    parameter int MEM_DEPTH = 256
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire [cpu8_pkg::WORD_W-1:0]  in_port,
    output logic [cpu8_pkg::WORD_W-1:0] out_port
);
    import cpu8_pkg::*;

    logic [WORD_W-1:0]    pc;
    logic [WORD_W-1:0]    instr_word;
    instr_u               ifid_word;
    logic                 stall;
    logic                 flush_ifid;
    logic                 bubble_idex;
    logic [1:0]           fwd_a;
    logic [1:0]           fwd_b;
    logic                 branch_taken;
    logic [WORD_W-1:0]    branch_target;
    logic [REG_IDX_W-1:0] rd_a_idx;
    logic [REG_IDX_W-1:0] rd_b_idx;
    logic [WORD_W-1:0]    rd_a_data;
    logic [WORD_W-1:0]    rd_b_data;
    logic [OPC_W-1:0]     idex_op;
    logic [REG_IDX_W-1:0] idex_ra_idx;
    logic [REG_IDX_W-1:0] idex_rb_idx;
    logic [WORD_W-1:0]    idex_a;
    logic [WORD_W-1:0]    idex_b;
    logic [WORD_W-1:0]    idex_aux;
    logic [1:0]           idex_res_sel;
    logic [REG_IDX_W-1:0] idex_dest;
    logic                 idex_reg_we;
    logic                 idex_mem_rd;
    logic                 idex_mem_we;
    logic                 idex_out_we;
    logic [WORD_W-1:0]    exmem_result;
    logic [WORD_W-1:0]    exmem_store;
    logic [REG_IDX_W-1:0] exmem_dest;
    logic                 exmem_reg_we;
    logic                 exmem_mem_rd;
    logic                 exmem_mem_we;
    logic                 exmem_out_we;
    logic [WORD_W-1:0]    mem_rdata;
    logic                 wb_en;
    logic [REG_IDX_W-1:0] wb_idx;
    logic [WORD_W-1:0]    wb_data;

    cpu8_fetch u_fetch (
        .clk(clk), .rst_n(rst_n), .instr_word(instr_word),
        .stall(stall), .flush_ifid(flush_ifid),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .pc(pc), .ifid_word(ifid_word)
    );

    cpu8_decode u_decode (
        .clk(clk), .rst_n(rst_n), .ifid_word(ifid_word), .in_port(in_port),
        .rd_a_data(rd_a_data), .rd_b_data(rd_b_data),
        .bubble_idex(bubble_idex), .branch_taken(branch_taken),
        .rd_a_idx(rd_a_idx), .rd_b_idx(rd_b_idx), .idex_op(idex_op),
        .idex_ra_idx(idex_ra_idx), .idex_rb_idx(idex_rb_idx),
        .idex_a(idex_a), .idex_b(idex_b), .idex_aux(idex_aux),
        .idex_res_sel(idex_res_sel), .idex_dest(idex_dest),
        .idex_reg_we(idex_reg_we), .idex_mem_rd(idex_mem_rd),
        .idex_mem_we(idex_mem_we), .idex_out_we(idex_out_we)
    );

    cpu8_regfile u_regfile (
        .clk(clk), .rst_n(rst_n), .rd_a_idx(rd_a_idx), .rd_b_idx(rd_b_idx),
        .wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data),
        .rd_a_data(rd_a_data), .rd_b_data(rd_b_data)
    );

    cpu8_hazard u_hazard (
        .ifid_word(ifid_word), .idex_dest(idex_dest), .idex_mem_rd(idex_mem_rd),
        .idex_ra_idx(idex_ra_idx), .idex_rb_idx(idex_rb_idx),
        .exmem_dest(exmem_dest), .exmem_reg_we(exmem_reg_we),
        .memwb_dest(wb_idx), .memwb_reg_we(wb_en),  // mem/wb lives in writeback
        .branch_taken(branch_taken), .stall(stall), .flush_ifid(flush_ifid),
        .bubble_idex(bubble_idex), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    cpu8_execute u_execute (
        .clk(clk), .rst_n(rst_n), .idex_op(idex_op),
        .idex_a(idex_a), .idex_b(idex_b), .idex_aux(idex_aux),
        .idex_res_sel(idex_res_sel), .idex_dest(idex_dest),
        .idex_reg_we(idex_reg_we), .idex_mem_rd(idex_mem_rd),
        .idex_mem_we(idex_mem_we), .idex_out_we(idex_out_we),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .wb_data(wb_data),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .exmem_result(exmem_result), .exmem_store(exmem_store),
        .exmem_dest(exmem_dest), .exmem_reg_we(exmem_reg_we),
        .exmem_mem_rd(exmem_mem_rd), .exmem_mem_we(exmem_mem_we),
        .exmem_out_we(exmem_out_we)
    );

    cpu8_memory #(
        .MEM_DEPTH(MEM_DEPTH)
    ) u_memory (
        .clk(clk), .addr_a(pc), .addr_b(exmem_result),  // ldd/std address in result
        .we_b(exmem_mem_we), .wdata_b(exmem_store),
        .rdata_a(instr_word), .rdata_b(mem_rdata)
    );

    cpu8_writeback u_writeback (
        .clk(clk), .rst_n(rst_n), .exmem_result(exmem_result),
        .exmem_dest(exmem_dest), .exmem_reg_we(exmem_reg_we),
        .exmem_mem_rd(exmem_mem_rd), .exmem_out_we(exmem_out_we),
        .exmem_store(exmem_store), .mem_rdata(mem_rdata),
        .wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data), .out_port(out_port)
    );

endmodule

`default_nettype wire

// File: cpu8_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu8_tb;
    import cpu8_pkg::*;

    localparam int MEM_DEPTH       = 256;
    localparam int CLK_PERIOD      = 100;
    localparam int RUN_CYCLES      = 60;
    localparam int N_TESTS         = 5;
    localparam int CYCLES_PER_TEST = 70;  // reset, load and run with margin

    logic              clk;
    logic              rst_n;
    logic [WORD_W-1:0] in_port;
    logic [WORD_W-1:0] out_port;

    logic [WORD_W-1:0] prog [MEM_DEPTH];  // program image for the backdoor
    int                plen;
    logic [WORD_W-1:0] exp_q [$];         // expected out_port changes
    logic [WORD_W-1:0] got_q [$];
    logic [WORD_W-1:0] last_exp;
    logic [31:0]       lfsr_state = 32'h6d98;
    int                word_errors = 0;
    int                count_errors = 0;

    cpu8_top #(
        .MEM_DEPTH(MEM_DEPTH)
    ) DUT (
        .clk(clk), .rst_n(rst_n), .in_port(in_port), .out_port(out_port)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_byte(output logic [WORD_W-1:0] v);
        for (int i = 0; i < WORD_W; i++) begin
            v[i]       = lfsr_state[0];  // one step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_word(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            word_errors++;
            $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            count_errors++;
            $display("[FAIL] %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic new_program();
        plen     = 0;
        last_exp = '0;  // out_port level right after reset
        exp_q.delete();
    endtask

    task automatic put(input logic [OPC_W-1:0] op, input int ra, input int rb);
        prog[plen] = {op, ra[REG_IDX_W-1:0], rb[REG_IDX_W-1:0]};
        plen++;
    endtask

    task automatic put_ldm(input int ra, input logic [WORD_W-1:0] imm);
        put(OP_LDM, ra, 0);
        prog[plen] = imm;  // second word
        plen++;
    endtask

    task automatic put_halt();
        put_ldm(3, 8'(plen + 2));  // address of the jmp itself
        put(OP_JMP, 0, 3);
    endtask

    // out_port is a level, so a repeated value is no new change
    task automatic expect_out(input logic [WORD_W-1:0] v);
        if (v != last_exp) begin
            exp_q.push_back(v);
        end
        last_exp = v;
    endtask

    task automatic load_program();
        for (int i = 0; i < MEM_DEPTH; i++) begin
            // filler past the program follows the address
            DUT.u_memory.mem[i] = (i < plen) ? prog[i] : (i[WORD_W-1:0] ^ 8'h3c);
        end
    endtask

    task automatic run_program(input logic [WORD_W-1:0] in_val);
        logic [WORD_W-1:0] last;
        @(negedge clk);
        rst_n   = 1'b0;
        in_port = in_val;  // held through the test
        @(negedge clk);
        load_program();    // backdoor during reset
        repeat (3) @(negedge clk);
        check_word(out_port, '0, "out_port after reset");
        rst_n = 1'b1;
        last  = '0;
        got_q.delete();
        repeat (RUN_CYCLES) begin
            @(negedge clk);  // out_port settled since the rising edge
            if (out_port !== last) begin
                got_q.push_back(out_port);
                last = out_port;
            end
        end
        check_count(got_q.size(), exp_q.size(), "number of out_port changes");
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check_word(got_q[i], exp_q[i], $sformatf("out_port change %0d", i));
        end
    endtask

    task automatic test_alu_ops();
        logic [WORD_W-1:0] a;
        logic [WORD_W-1:0] b;
        new_program();
        draw_byte(a);
        draw_byte(b);
        put_ldm(0, a);
        put_ldm(1, b);
        put(OP_MOV, 2, 0);
        put(OP_ADD, 2, 1);
        put(OP_OUT, 2, 0);
        expect_out(a + b);
        put(OP_MOV, 2, 0);
        put(OP_SUB, 2, 1);
        put(OP_OUT, 2, 0);
        expect_out(a - b);
        put(OP_MOV, 2, 0);
        put(OP_AND, 2, 1);
        put(OP_OUT, 2, 0);
        expect_out(a & b);
        put(OP_MOV, 2, 0);
        put(OP_OR, 2, 1);
        put(OP_OUT, 2, 0);
        expect_out(a | b);
        put(OP_MOV, 2, 1);
        put(OP_OUT, 2, 0);
        expect_out(b);
        put_halt();
        run_program('0);
    endtask

    task automatic test_forwarding();
        logic [WORD_W-1:0] r0;
        logic [WORD_W-1:0] r1;
        new_program();
        draw_byte(r0);
        draw_byte(r1);
        put_ldm(0, r0);
        put_ldm(1, r1);
        put(OP_ADD, 0, 1);  // r0 = a + b
        r0 = r0 + r1;
        put(OP_ADD, 0, 0);  // both operands from mem
        r0 = r0 + r0;
        put(OP_OUT, 0, 0);
        expect_out(r0);
        put(OP_SUB, 1, 0);  // r0 from wb
        r1 = r1 - r0;
        put(OP_OR, 0, 1);   // r1 from mem
        r0 = r0 | r1;
        put(OP_NOP, 0, 0);
        put(OP_OUT, 1, 0);  // sub three ahead, write-through
        expect_out(r1);
        put(OP_AND, 1, 0);  // or three ahead
        r1 = r1 & r0;
        put(OP_OUT, 1, 0);
        expect_out(r1);
        put(OP_OUT, 0, 0);
        expect_out(r0);
        put_halt();
        run_program('0);
    endtask

    task automatic test_load_store();
        logic [WORD_W-1:0] v0;
        logic [WORD_W-1:0] v1;
        logic [WORD_W-1:0] a0;
        logic [WORD_W-1:0] a1;
        new_program();
        draw_byte(v0);
        draw_byte(v1);
        draw_byte(a0);
        a0[WORD_W-1] = 1'b1;  // data above the program
        a1           = a0 ^ 8'h40;
        put_ldm(0, v0);
        put_ldm(1, a0);
        put(OP_STD, 0, 1);
        put_ldm(2, v1);
        put_ldm(3, a1);
        put(OP_STD, 2, 3);
        put(OP_LDD, 0, 1);
        put(OP_OUT, 0, 0);  // load-use on ra
        expect_out(v0);
        put(OP_LDD, 1, 3);
        put(OP_ADD, 1, 0);  // load-use again
        put(OP_OUT, 1, 0);
        expect_out(v1 + v0);
        put_halt();
        run_program('0);
        check_word(DUT.u_memory.mem[a0], v0, "stored word at first address");
        check_word(DUT.u_memory.mem[a1], v1, "stored word at second address");
    endtask

    // marker outs in the two shadow slots, target prints its own address
    task automatic branch_block(input logic [OPC_W-1:0] op, input logic taken);
        logic [WORD_W-1:0] target;
        target = 8'(plen + 5);
        put_ldm(3, target);
        put(op, 0, 3);
        put(OP_OUT, 2, 0);
        put(OP_OUT, 2, 0);
        put(OP_OUT, 3, 0);
        if (!taken) begin
            expect_out(8'h5a);
        end
        expect_out(target);
    endtask

    task automatic test_branches();
        logic [WORD_W-1:0] x;
        logic [WORD_W-1:0] y;
        logic [WORD_W-1:0] p;
        logic [WORD_W-1:0] q;
        logic [WORD_W:0]   sum;  // carry in the top bit
        new_program();
        draw_byte(x);
        draw_byte(y);
        draw_byte(p);
        draw_byte(q);
        y = x ^ (y | 8'h01);  // never equal to x
        put_ldm(2, 8'h5a);    // marker
        put_ldm(0, x);
        put(OP_MOV, 1, 0);
        put(OP_SUB, 0, 1);
        branch_block(OP_JZ, (x - x) == 0);
        put_ldm(0, y);
        put(OP_SUB, 0, 1);
        branch_block(OP_JZ, (y - x) == 0);
        put_ldm(0, p | 8'h80);
        put_ldm(1, q | 8'h80);
        put(OP_ADD, 0, 1);
        sum = {1'b0, p | 8'h80} + {1'b0, q | 8'h80};
        branch_block(OP_JC, sum[WORD_W]);
        put_ldm(0, p & 8'h7f);
        put(OP_MOV, 1, 0);
        put(OP_ADD, 0, 1);
        sum = {1'b0, p & 8'h7f} + {1'b0, p & 8'h7f};
        branch_block(OP_JC, sum[WORD_W]);
        branch_block(OP_JMP, 1'b1);
        put_halt();
        run_program('0);
    endtask

    task automatic test_in_port();
        logic [WORD_W-1:0] v;
        new_program();
        draw_byte(v);
        put(OP_IN, 0, 0);
        put(OP_IN, 1, 0);
        put(OP_ADD, 0, 1);
        put(OP_OUT, 1, 0);
        expect_out(v);
        put(OP_OUT, 0, 0);
        expect_out(v + v);
        put_halt();
        run_program(v);
    endtask

    initial begin
        #(N_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        $display("test failed");
        $finish;
    end

    initial begin
        rst_n   = 1'b0;
        in_port = '0;
        test_alu_ops();
        test_forwarding();
        test_load_store();
        test_branches();
        test_in_port();
        $display("errors: %0d value, %0d count", word_errors, count_errors);
        if (word_errors == 0 && count_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cpu8_top.f
cpu8_pkg.sv
cpu8_fetch.sv
cpu8_regfile.sv
cpu8_decode.sv
cpu8_hazard.sv
cpu8_execute.sv
cpu8_memory.sv
cpu8_writeback.sv
cpu8_top.sv
cpu8_tb.sv

// File: Bender.yml
package:
  name: cpu8

sources:
  - cpu8_pkg.sv
  - cpu8_fetch.sv
  - cpu8_regfile.sv
  - cpu8_decode.sv
  - cpu8_hazard.sv
  - cpu8_execute.sv
  - cpu8_memory.sv
  - cpu8_writeback.sv
  - cpu8_top.sv
  - target: test
    files:
      - cpu8_tb.sv
